// File: source/uart_pkg.sv
`default_nettype none

package uart_pkg;

	// Data bits in one serial frame
	localparam int uart_data_bits = 8;

	// Stop bits at the end of each frame
	localparam int uart_stop_bits = 1;

endpackage

`default_nettype wire

// File: source/dbg_cmd_pkg.sv
`default_nettype none

package dbg_cmd_pkg;

	// Host command opcodes, one byte each
	localparam logic [7:0] cmd_halt_cpu          = 8'h00;
	localparam logic [7:0] cmd_resume_cpu        = 8'h01;
	localparam logic [7:0] cmd_write_byte        = 8'h02;
	localparam logic [7:0] cmd_read_byte         = 8'h03;
	localparam logic [7:0] cmd_reset_cpu         = 8'h04;
	localparam logic [7:0] cmd_ping              = 8'h05;
	localparam logic [7:0] cmd_hold_cpu_reset    = 8'h06;
	localparam logic [7:0] cmd_release_cpu_reset = 8'h07;

	// Reply for every command except a read
	localparam logic [7:0] ack_byte = 8'h00;

	// Reset pulse ends when the counter MSB sets
	localparam int reset_pulse_bits = 9;

	// Target bus address width
	localparam int addr_width = 16;

endpackage

`default_nettype wire

// File: source/uart_rx.sv
`default_nettype none

module uart_rx import uart_pkg::*; #(
	parameter int clks_per_bit = 8
) (
	input wire clk,
	input wire rst,
	input wire serial_in,
	output logic rx_valid,
	output logic [7:0] rx_data
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam int idx_w = $clog2(uart_data_bits);
	localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);
	localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);
	localparam logic [idx_w-1:0] data_last = idx_w'(uart_data_bits - 1);

	localparam logic [1:0] st_idle  = 2'd0;
	localparam logic [1:0] st_start = 2'd1;
	localparam logic [1:0] st_data  = 2'd2;
	localparam logic [1:0] st_stop  = 2'd3;

	logic [1:0] sync;
	logic rx_s;
	logic [1:0] state;
	logic [cnt_w-1:0] cnt;
	logic [idx_w-1:0] idx;
	logic [7:0] shreg;

	// Synchronized line level
	assign rx_s = sync[1];
	assign rx_data = shreg;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			// Line idles high, so no false start out of reset
			sync <= 2'b11;
			state <= st_idle;
			cnt <= '0;
			idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			sync <= {sync[0], serial_in};
			rx_valid <= 1'b0;
			case (state)
				st_idle: begin
					// Falling edge starts a frame
					if (!rx_s) begin
						state <= st_start;
						cnt <= '0;
					end
				end
				st_start: begin
					if (cnt == half_last) begin
						cnt <= '0;
						// Still low at mid-bit, so a real start bit
						if (!rx_s) begin
							state <= st_data;
							idx <= '0;
						end else begin
							state <= st_idle;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_data: begin
					if (cnt == bit_last) begin
						cnt <= '0;
						idx <= idx + 1'b1;
						// Byte complete after last data bit
						if (idx == data_last) begin
							state <= st_stop;
							rx_valid <= 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					// Wait for a high stop bit before rearming
					if (cnt == bit_last) begin
						if (rx_s)
							state <= st_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// Shift in LSB first at each data bit centre
	always_ff @(posedge clk) begin
		if (state == st_data && cnt == bit_last)
			shreg <= {rx_s, shreg[7:1]};
	end

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`default_nettype none

module uart_tx import uart_pkg::*; #(
	parameter int clks_per_bit = 8
) (
	input wire clk,
	input wire rst,
	input wire tx_start,
	input wire [7:0] tx_data,
	output logic serial_out,
	output logic tx_ready
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam int idx_w = $clog2(uart_data_bits);
	localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);
	localparam logic [idx_w-1:0] data_last = idx_w'(uart_data_bits - 1);
	localparam logic [idx_w-1:0] stop_last = idx_w'(uart_stop_bits - 1);

	localparam logic [1:0] st_idle  = 2'd0;
	localparam logic [1:0] st_start = 2'd1;
	localparam logic [1:0] st_data  = 2'd2;
	localparam logic [1:0] st_stop  = 2'd3;

	logic [1:0] state;
	logic [cnt_w-1:0] cnt;
	logic [idx_w-1:0] idx;
	logic [7:0] shreg;

	// Ready whenever no frame is on the line
	assign tx_ready = (state == st_idle);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_idle;
			cnt <= '0;
			idx <= '0;
			serial_out <= 1'b1;
		end else begin
			if (state == st_idle) begin
				// Start bit goes out the cycle after tx_start
				if (tx_start) begin
					state <= st_start;
					cnt <= '0;
					serial_out <= 1'b0;
				end
			end else if (cnt != bit_last) begin
				cnt <= cnt + 1'b1;
			end else begin
				// End of one bit period
				cnt <= '0;
				case (state)
					st_start: begin
						state <= st_data;
						idx <= '0;
						serial_out <= shreg[0];
					end
					st_data: begin
						idx <= idx + 1'b1;
						if (idx == data_last) begin
							state <= st_stop;
							idx <= '0;
							serial_out <= 1'b1;
						end else begin
							serial_out <= shreg[1];
						end
					end
					default: begin
						idx <= idx + 1'b1;
						if (idx == stop_last)
							state <= st_idle;
					end
				endcase
			end
		end
	end

	// Byte latched on start, then shifted right LSB first
	always_ff @(posedge clk) begin
		if (state == st_idle && tx_start)
			shreg <= tx_data;
		else if (state == st_data && cnt == bit_last)
			shreg <= {1'b0, shreg[7:1]};
	end

endmodule

`default_nettype wire

// File: source/sys_ctrl_fsm.sv
`default_nettype none

module sys_ctrl_fsm import dbg_cmd_pkg::*; (
	input wire clk,
	input wire rst,
	input wire rx_valid,
	input wire [7:0] rx_data,
	input wire tx_ready,
	output logic tx_start,
	output logic [7:0] tx_data,
	input wire cpu_is_halted,
	output logic cpu_halt,
	output logic cpu_rst,
	output logic bus_grant,
	output logic [addr_width-1:0] bus_addr,
	output logic [7:0] bus_wdata,
	output logic bus_we,
	output logic bus_re,
	input wire [7:0] bus_rdata
);

	localparam logic [3:0] st_idle       = 4'd0;
	localparam logic [3:0] st_rd_hi      = 4'd1;
	localparam logic [3:0] st_rd_lo      = 4'd2;
	localparam logic [3:0] st_rd_wait    = 4'd3;
	localparam logic [3:0] st_rd_reply   = 4'd4;
	localparam logic [3:0] st_wr_hi      = 4'd5;
	localparam logic [3:0] st_wr_lo      = 4'd6;
	localparam logic [3:0] st_wr_data    = 4'd7;
	localparam logic [3:0] st_reset_hold = 4'd8;
	localparam logic [3:0] st_send_ack   = 4'd9;

	logic [3:0] state;
	logic [reset_pulse_bits-1:0] cnt;
	logic we_q;
	logic re_q;

	// Bus is ours only with the CPU confirmed halted or held in reset
	assign bus_grant = (cpu_halt && cpu_is_halted) || !cpu_rst;
	assign bus_we = we_q && bus_grant;
	assign bus_re = re_q && bus_grant;

	// Control registers back to their reset values
	task automatic clear_ctrl();
		state <= st_idle;
		cnt <= '0;
		we_q <= 1'b0;
		re_q <= 1'b0;
		tx_start <= 1'b0;
		cpu_halt <= 1'b0;
		cpu_rst <= 1'b1;
	endtask

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			clear_ctrl();
		end else begin
			// Strobes last a single cycle
			tx_start <= 1'b0;
			we_q <= 1'b0;
			re_q <= 1'b0;
			case (state)
				st_idle: begin
					cnt <= '0;
					if (rx_valid) begin
						case (rx_data)
							cmd_halt_cpu: begin
								cpu_halt <= 1'b1;
								state <= st_send_ack;
							end
							cmd_resume_cpu: begin
								cpu_halt <= 1'b0;
								state <= st_send_ack;
							end
							cmd_write_byte: state <= st_wr_hi;
							cmd_read_byte: state <= st_rd_hi;
							cmd_reset_cpu: begin
								cpu_rst <= 1'b0;
								state <= st_reset_hold;
							end
							cmd_ping: state <= st_send_ack;
							cmd_hold_cpu_reset: begin
								cpu_rst <= 1'b0;
								state <= st_send_ack;
							end
							cmd_release_cpu_reset: begin
								cpu_rst <= 1'b1;
								state <= st_send_ack;
							end
							// Unknown opcode drops everything silently
							default: clear_ctrl();
						endcase
					end
				end
				// Address bytes arrive high first
				st_rd_hi: if (rx_valid) state <= st_rd_lo;
				st_rd_lo: begin
					if (rx_valid) begin
						re_q <= 1'b1;
						state <= st_rd_wait;
					end
				end
				// Read enable on the bus this cycle
				st_rd_wait: state <= st_rd_reply;
				st_rd_reply: begin
					if (tx_ready) begin
						tx_start <= 1'b1;
						state <= st_idle;
					end
				end
				st_wr_hi: if (rx_valid) state <= st_wr_lo;
				st_wr_lo: if (rx_valid) state <= st_wr_data;
				st_wr_data: begin
					// Write fires the cycle after the data byte
					if (rx_valid) begin
						we_q <= 1'b1;
						state <= st_send_ack;
					end
				end
				st_reset_hold: begin
					// MSB set means 256 counted, so the pulse spans 257 cycles
					if (cnt[reset_pulse_bits-1]) begin
						cpu_rst <= 1'b1;
						state <= st_send_ack;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_send_ack: begin
					if (tx_ready) begin
						tx_start <= 1'b1;
						state <= st_idle;
					end
				end
				default: clear_ctrl();
			endcase
		end
	end

	// Address, write data and reply byte
	always_ff @(posedge clk) begin
		if (rx_valid && (state == st_rd_hi || state == st_wr_hi))
			bus_addr[15:8] <= rx_data;
		if (rx_valid && (state == st_rd_lo || state == st_wr_lo))
			bus_addr[7:0] <= rx_data;
		if (rx_valid && state == st_wr_data)
			bus_wdata <= rx_data;
		// RAM output valid once the reply state is reached
		if (state == st_rd_reply)
			tx_data <= bus_rdata;
		else if (state == st_send_ack)
			tx_data <= ack_byte;
	end

endmodule

`default_nettype wire

// File: source/target_ram.sv
`default_nettype none

module target_ram import dbg_cmd_pkg::*; (
	input wire clk,
	input wire we,
	input wire re,
	input wire [addr_width-1:0] addr,
	input wire [7:0] wdata,
	output logic [7:0] rdata
);

	// Only the low address byte selects a word
	logic [7:0] mem [0:255];
	logic [7:0] word_sel;

	assign word_sel = addr[7:0];

	always_ff @(posedge clk) begin
		// Byte write
		if (we)
			mem[word_sel] <= wdata;
		// Registered read, data one cycle after re
		if (re)
			rdata <= mem[word_sel];
	end

endmodule

`default_nettype wire

// File: source/debug_uart_top.sv
`default_nettype none

module debug_uart_top import dbg_cmd_pkg::*; #(
	parameter int clks_per_bit = 8
) (
	input wire clk,
	input wire rst,
	input wire uart_rx,
	output wire uart_tx,
	input wire [addr_width-1:0] cpu_addr,
	input wire [7:0] cpu_wdata,
	input wire cpu_we,
	input wire cpu_re,
	output wire [7:0] cpu_rdata,
	output wire cpu_halt,
	output wire cpu_rst,
	input wire cpu_is_halted,
	output wire bus_grant
);

	wire rx_valid;
	wire [7:0] rx_data;
	wire tx_start;
	wire [7:0] tx_data;
	wire tx_ready;

	// Debug side of the RAM bus
	wire [addr_width-1:0] dbg_addr;
	wire [7:0] dbg_wdata;
	wire dbg_we;
	wire dbg_re;

	// RAM port after the ownership mux
	wire [addr_width-1:0] ram_addr;
	wire [7:0] ram_wdata;
	wire ram_we;
	wire ram_re;
	wire [7:0] ram_rdata;

	uart_rx #(
		.clks_per_bit(clks_per_bit)
	) uart_rx_inst (
		.clk(clk),
		.rst(rst),
		.serial_in(uart_rx),
		.rx_valid(rx_valid),
		.rx_data(rx_data)
	);

	sys_ctrl_fsm sys_ctrl_fsm_inst (
		.clk(clk),
		.rst(rst),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.tx_ready(tx_ready),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.cpu_is_halted(cpu_is_halted),
		.cpu_halt(cpu_halt),
		.cpu_rst(cpu_rst),
		.bus_grant(bus_grant),
		.bus_addr(dbg_addr),
		.bus_wdata(dbg_wdata),
		.bus_we(dbg_we),
		.bus_re(dbg_re),
		.bus_rdata(ram_rdata)
	);

	// Grant hands the whole RAM port to the debug side
	assign ram_addr = bus_grant ? dbg_addr : cpu_addr;
	assign ram_wdata = bus_grant ? dbg_wdata : cpu_wdata;
	assign ram_we = bus_grant ? dbg_we : cpu_we;
	assign ram_re = bus_grant ? dbg_re : cpu_re;

	// Read data is shared by both masters
	assign cpu_rdata = ram_rdata;

	target_ram target_ram_inst (
		.clk(clk),
		.we(ram_we),
		.re(ram_re),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

	uart_tx #(
		.clks_per_bit(clks_per_bit)
	) uart_tx_inst (
		.clk(clk),
		.rst(rst),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.serial_out(uart_tx),
		.tx_ready(tx_ready)
	);

endmodule

`default_nettype wire

// File: dv/debug_uart_chk.sv
`default_nettype none

module debug_uart_chk (
	input wire clk,
	input wire rst,
	input wire tx_start,
	input wire tx_ready,
	input wire bus_grant,
	input wire we_req,
	input wire re_req,
	input wire bus_we,
	input wire bus_re
);

	// Transmitter must be idle when a reply starts
	a_start_ready: assert property (@(posedge clk) disable iff (!rst) tx_start |-> tx_ready)
		else $error("tx_start raised while the transmitter was busy");

	// Sequencer asks for the bus only once it owns it
	a_grant: assert property (@(posedge clk) disable iff (!rst) (we_req || re_req) |-> bus_grant)
		else $error("Debug bus access requested without bus_grant");

	a_exclusive: assert property (@(posedge clk) disable iff (!rst) !(bus_we && bus_re))
		else $error("bus_we and bus_re high together");

	// Single-cycle enables
	a_we_pulse: assert property (@(posedge clk) disable iff (!rst) bus_we |=> !bus_we)
		else $error("bus_we held longer than one cycle");

	a_re_pulse: assert property (@(posedge clk) disable iff (!rst) bus_re |=> !bus_re)
		else $error("bus_re held longer than one cycle");

endmodule

`default_nettype wire

// File: dv/debug_uart_monitor.sv
`default_nettype none

module debug_uart_monitor #(
	parameter int clks_per_bit = 8
) (
	input wire clk,
	input wire rst,
	input wire uart_tx,
	input wire cpu_halt,
	input wire cpu_rst,
	input wire bus_grant,
	input wire [15:0] cpu_addr,
	input wire [7:0] cpu_wdata,
	input wire cpu_we,
	input wire cpu_re,
	input wire [7:0] cpu_rdata,
	input wire [191:0] test_name,
	input wire arm,
	input wire check_end,
	input wire exp_reply,
	input wire [7:0] exp_byte,
	input int exp_halt,
	input int exp_rst,
	input int exp_pulse,
	output logic reply_pending,
	output int err_reply,
	output int err_cpu,
	output int err_pulse
);

	int dstate;
	int dcnt;
	int bidx;
	logic [7:0] dbyte;
	int low_cnt;
	logic pulse_seen;
	logic [7:0] shadow [0:255];
	logic known [0:255];
	logic rd_pending;
	logic [7:0] rd_idx;

	// Serial reply decoder, levels checked at the end of each test
	always @(posedge clk) begin
		if (!rst) begin
			dstate = 0;
			dcnt = 0;
			bidx = 0;
			reply_pending = 1'b0;
			err_reply = 0;
		end else begin
			if (arm)
				reply_pending = exp_reply;
			if (check_end) begin
				if (reply_pending) begin
					err_reply++;
					$display("No reply arrived for test %0s", test_name);
					reply_pending = 1'b0;
				end
				if (exp_halt != 2 && int'(cpu_halt) != exp_halt) begin
					err_reply++;
					$display("FAIL %0s: cpu_halt expected %0d, actual %0d",
						test_name, exp_halt, cpu_halt);
				end
				if (exp_rst != 2 && int'(cpu_rst) != exp_rst) begin
					err_reply++;
					$display("FAIL %0s: cpu_rst expected %0d, actual %0d",
						test_name, exp_rst, cpu_rst);
				end
			end
			case (dstate)
				0: begin
					if (!uart_tx) begin
						dstate = 1;
						dcnt = 1;
					end
				end
				// Start bit confirmed at its middle
				1: begin
					if (dcnt == clks_per_bit / 2) begin
						dcnt = 0;
						bidx = 0;
						dstate = uart_tx ? 0 : 2;
					end else begin
						dcnt++;
					end
				end
				2: begin
					dcnt++;
					if (dcnt == clks_per_bit) begin
						dcnt = 0;
						dbyte[bidx] = uart_tx;
						bidx++;
						if (bidx == 8)
							dstate = 3;
					end
				end
				default: begin
					dcnt++;
					if (dcnt == clks_per_bit) begin
						dstate = 0;
						if (!uart_tx) begin
							err_reply++;
							$display("Reply stop bit was low during test %0s", test_name);
						end
						if (reply_pending) begin
							reply_pending = 1'b0;
							if (dbyte != exp_byte) begin
								err_reply++;
								$display("FAIL %0s: reply expected 0x%02h, actual 0x%02h",
									test_name, exp_byte, dbyte);
							end
						end else begin
							err_reply++;
							$display("Unexpected reply byte 0x%02h during test %0s",
								dbyte, test_name);
						end
					end
				end
			endcase
		end
	end

	// Width of each cpu_rst low pulse in cycles
	always @(posedge clk) begin
		if (!rst) begin
			low_cnt = 0;
			pulse_seen = 1'b0;
			err_pulse = 0;
		end else begin
			if (arm)
				pulse_seen = 1'b0;
			if (!cpu_rst) begin
				low_cnt++;
			end else if (low_cnt != 0) begin
				if (exp_pulse != 0) begin
					pulse_seen = 1'b1;
					if (low_cnt != exp_pulse) begin
						err_pulse++;
						$display("FAIL %0s: cpu_rst low cycles expected %0d, actual %0d",
							test_name, exp_pulse, low_cnt);
					end
				end
				low_cnt = 0;
			end
			if (check_end && exp_pulse != 0 && !pulse_seen) begin
				err_pulse++;
				$display("No cpu_rst pulse was seen in test %0s", test_name);
			end
		end
	end

	// CPU side of the RAM port, shadow copy of CPU writes
	always @(posedge clk) begin
		if (!rst) begin
			rd_pending = 1'b0;
			err_cpu = 0;
			for (int i = 0; i < 256; i++)
				known[i] = 1'b0;
		end else begin
			if (rd_pending && cpu_rdata != shadow[rd_idx]) begin
				err_cpu++;
				$display("FAIL %0s: cpu_rdata expected 0x%02h, actual 0x%02h",
					test_name, shadow[rd_idx], cpu_rdata);
			end
			rd_pending = 1'b0;
			if ((cpu_we || cpu_re) && bus_grant) begin
				err_cpu++;
				$display("CPU access while the debug controller owned the bus in %0s",
					test_name);
			end
			if (cpu_we && !bus_grant) begin
				shadow[cpu_addr[7:0]] = cpu_wdata;
				known[cpu_addr[7:0]] = 1'b1;
			end
			if (cpu_re && !bus_grant && known[cpu_addr[7:0]]) begin
				rd_pending = 1'b1;
				rd_idx = cpu_addr[7:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/tb_debug_uart.sv
`default_nettype none

module tb_debug_uart;

	localparam int clks_per_bit = 8;

	logic clk;
	logic rst;
	logic uart_rx_line;
	wire uart_tx_line;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_wdata;
	logic cpu_we;
	logic cpu_re;
	wire [7:0] cpu_rdata;
	wire cpu_halt;
	wire cpu_rst;
	logic cpu_is_halted = 1'b0;
	logic halt_d = 1'b0;
	wire bus_grant;

	// Expectations handed to the monitor
	logic [191:0] cur_name;
	logic arm;
	logic check_end;
	logic exp_reply;
	logic [7:0] exp_byte;
	int exp_halt;
	int exp_rst;
	int exp_pulse;
	logic reply_pending;
	int err_reply;
	int err_cpu;
	int err_pulse;
	int tb_errors;

	// Test table from the data file
	logic [7:0] kinds [0:63];
	logic [191:0] names [0:63];
	int counts [0:63];
	logic [7:0] tbytes [0:63][0:3];
	int has_rep [0:63];
	logic [7:0] replies [0:63];
	int ehalt [0:63];
	int erst [0:63];
	int epulse [0:63];
	int num_lines;

	logic [31:0] rng = 32'd15384;
	logic [7:0] shadow [0:255];
	logic [15:0] cpu_addrs [0:15];
	int cycles;
	int cycle_limit;
	logic limit_ready;
	int total_err;

	debug_uart_top #(
		.clks_per_bit(clks_per_bit)
	) debug_uart_top_inst (
		.clk(clk),
		.rst(rst),
		.uart_rx(uart_rx_line),
		.uart_tx(uart_tx_line),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_we(cpu_we),
		.cpu_re(cpu_re),
		.cpu_rdata(cpu_rdata),
		.cpu_halt(cpu_halt),
		.cpu_rst(cpu_rst),
		.cpu_is_halted(cpu_is_halted),
		.bus_grant(bus_grant)
	);

	debug_uart_monitor #(
		.clks_per_bit(clks_per_bit)
	) monitor_inst (
		.clk(clk),
		.rst(rst),
		.uart_tx(uart_tx_line),
		.cpu_halt(cpu_halt),
		.cpu_rst(cpu_rst),
		.bus_grant(bus_grant),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_we(cpu_we),
		.cpu_re(cpu_re),
		.cpu_rdata(cpu_rdata),
		.test_name(cur_name),
		.arm(arm),
		.check_end(check_end),
		.exp_reply(exp_reply),
		.exp_byte(exp_byte),
		.exp_halt(exp_halt),
		.exp_rst(exp_rst),
		.exp_pulse(exp_pulse),
		.reply_pending(reply_pending),
		.err_reply(err_reply),
		.err_cpu(err_cpu),
		.err_pulse(err_pulse)
	);

	bind sys_ctrl_fsm debug_uart_chk chk_inst (
		.clk(clk),
		.rst(rst),
		.tx_start(tx_start),
		.tx_ready(tx_ready),
		.bus_grant(bus_grant),
		.we_req(we_q),
		.re_req(re_q),
		.bus_we(bus_we),
		.bus_re(bus_re)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// CPU model acknowledges a halt two cycles later
	always @(negedge clk) begin
		halt_d <= cpu_halt;
		cpu_is_halted <= halt_d;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// One 8N1 frame, then two idle bit times
	task automatic send_byte(input logic [7:0] b);
		int i;
		uart_rx_line = 1'b0;
		repeat (clks_per_bit) @(negedge clk);
		for (i = 0; i < 8; i++) begin
			uart_rx_line = b[i];
			repeat (clks_per_bit) @(negedge clk);
		end
		uart_rx_line = 1'b1;
		repeat (3 * clks_per_bit) @(negedge clk);
	endtask

	task automatic run_cmd(input int n, input logic [7:0] b0, input logic [7:0] b1,
		input logic [7:0] b2, input logic [7:0] b3, input int reply_en,
		input logic [7:0] reply, input int eh, input int er, input int ep);
		int waited;
		exp_reply = (reply_en != 0);
		exp_byte = reply;
		exp_halt = eh;
		exp_rst = er;
		exp_pulse = ep;
		arm = 1'b1;
		@(negedge clk);
		arm = 1'b0;
		send_byte(b0);
		if (n > 1)
			send_byte(b1);
		if (n > 2)
			send_byte(b2);
		if (n > 3)
			send_byte(b3);
		waited = 0;
		// Bounded reply wait or a fixed quiet window
		if (reply_en != 0) begin
			while (reply_pending && waited < 80 * clks_per_bit) begin
				@(negedge clk);
				waited++;
			end
		end else begin
			repeat (40 * clks_per_bit) @(negedge clk);
		end
		check_end = 1'b1;
		@(negedge clk);
		check_end = 1'b0;
	endtask

	// CPU writes then reads back while it owns the bus
	task automatic cpu_exercise(input int n);
		int i;
		logic [15:0] a;
		logic [7:0] d;
		for (i = 0; i < n; i++) begin
			rng = xorshift32(rng);
			a = rng[15:0];
			rng = xorshift32(rng);
			d = rng[7:0];
			cpu_addr = a;
			cpu_wdata = d;
			cpu_we = 1'b1;
			@(negedge clk);
			cpu_we = 1'b0;
			cpu_re = 1'b1;
			@(negedge clk);
			cpu_re = 1'b0;
			@(negedge clk);
			shadow[a[7:0]] = d;
			cpu_addrs[i] = a;
		end
	endtask

	task automatic load_tests();
		int fd;
		int r;
		int frames;
		string line;
		logic [7:0] kc;
		logic [191:0] nm;
		int n;
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
		int hr;
		logic [7:0] rp;
		int eh;
		int er;
		int ep;
		num_lines = 0;
		frames = 0;
		fd = $fopen("dv/debug_uart_testdata.txt", "r");
		if (fd == 0) begin
			tb_errors++;
			$display("Cannot open the test data file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				r = $fgets(line, fd);
				if (r != 0 && line.len() > 1 && line.getc(0) != "#") begin
					r = $sscanf(line, "%s %s %d %h %h %h %h %d %h %d %d %d",
						kc, nm, n, b0, b1, b2, b3, hr, rp, eh, er, ep);
					if (r == 12 && num_lines < 64) begin
						kinds[num_lines] = kc;
						names[num_lines] = nm;
						counts[num_lines] = n;
						tbytes[num_lines][0] = b0;
						tbytes[num_lines][1] = b1;
						tbytes[num_lines][2] = b2;
						tbytes[num_lines][3] = b3;
						has_rep[num_lines] = hr;
						replies[num_lines] = rp;
						ehalt[num_lines] = eh;
						erst[num_lines] = er;
						epulse[num_lines] = ep;
						// Frames on the line bound the run length
						if (kc == "V")
							frames += 4 * n;
						else if (kc == "C")
							frames += 1;
						else
							frames += n + 1;
						num_lines++;
					end else begin
						tb_errors++;
						$display("Malformed test data line: %0s", line);
					end
				end
			end
			$fclose(fd);
		end
		cycle_limit = frames * 40 * clks_per_bit + 2000;
		limit_ready = 1'b1;
	endtask

	// Run limit
	initial begin
		cycles = 0;
		wait (limit_ready === 1'b1);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the tests did not finish", cycle_limit);
		$display("Errors found");
		$finish;
	end

	initial begin
		int i;
		int j;
		rst = 1'b0;
		uart_rx_line = 1'b1;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_we = 1'b0;
		cpu_re = 1'b0;
		arm = 1'b0;
		check_end = 1'b0;
		exp_reply = 1'b0;
		exp_byte = '0;
		exp_halt = 2;
		exp_rst = 2;
		exp_pulse = 0;
		cur_name = '0;
		tb_errors = 0;
		limit_ready = 1'b0;
		load_tests();
		repeat (16) @(negedge clk);
		rst = 1'b1;
		repeat (4) @(negedge clk);
		for (i = 0; i < num_lines; i++) begin
			cur_name = names[i];
			if (kinds[i] == "C") begin
				cpu_exercise(counts[i]);
			end else if (kinds[i] == "V") begin
				// Debug reads of the CPU-written addresses
				for (j = 0; j < counts[i]; j++)
					run_cmd(3, 8'h03, cpu_addrs[j][15:8], cpu_addrs[j][7:0], 8'h00, 1,
						shadow[cpu_addrs[j][7:0]], ehalt[i], erst[i], epulse[i]);
			end else begin
				run_cmd(counts[i], tbytes[i][0], tbytes[i][1], tbytes[i][2], tbytes[i][3],
					has_rep[i], replies[i], ehalt[i], erst[i], epulse[i]);
			end
		end
		repeat (4) @(negedge clk);
		total_err = err_reply + err_cpu + err_pulse + tb_errors;
		$display("Done: %0d errors (reply %0d, cpu bus %0d, reset pulse %0d, setup %0d)",
			total_err, err_reply, err_cpu, err_pulse, tb_errors);
		if (total_err == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
source/uart_pkg.sv
source/dbg_cmd_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/sys_ctrl_fsm.sv
source/target_ram.sv
source/debug_uart_top.sv
dv/debug_uart_chk.sv
dv/debug_uart_monitor.sv
dv/tb_debug_uart.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_debug_uart -Mdir obj_dir
	obj_dir/Vtb_debug_uart | tee sim.log
	@if grep -q "Errors found" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "No errors" sim.log || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: dv/debug_uart_testdata.txt
# kind name nbytes byte0 byte1 byte2 byte3 has_reply reply(hex) halt rst pulse
# S sends bytes, C runs CPU-side accesses, V reads the C addresses back; 2 = level not checked
S ping           1 05 00 00 00 1 00 2 1 0
S halt           1 00 00 00 00 1 00 1 1 0
S write_a        4 02 12 34 5a 1 00 1 1 0
S write_b        4 02 00 a7 c3 1 00 1 1 0
S write_c        4 02 ff 01 3c 1 00 1 1 0
S read_a         3 03 12 34 00 1 5a 1 1 0
S read_b         3 03 00 a7 00 1 c3 1 1 0
S read_c         3 03 ff 01 00 1 3c 1 1 0
S resume         1 01 00 00 00 1 00 0 1 0
C cpu_side       8 00 00 00 00 0 00 2 2 0
S halt_again     1 00 00 00 00 1 00 1 1 0
V cpu_readback   8 00 00 00 00 1 00 1 1 0
S resume_again   1 01 00 00 00 1 00 0 1 0
S reset_pulse    1 04 00 00 00 1 00 0 1 257
S hold_reset     1 06 00 00 00 1 00 0 0 0
S write_in_reset 4 02 00 10 99 1 00 0 0 0
S read_in_reset  3 03 00 10 00 1 99 0 0 0
S release_reset  1 07 00 00 00 1 00 0 1 0
S halt_third     1 00 00 00 00 1 00 1 1 0
S unknown_op     1 09 00 00 00 0 00 0 1 0
S ping_after     1 05 00 00 00 1 00 0 1 0
